//--- hw/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    // Array geometry
    localparam int PE_ROW = 4;
    localparam int PE_COL = 4;

    // Field and bus widths
    localparam int DATA_W   = 8;
    localparam int ADDR_W   = 10;
    localparam int SEL_W    = 2;
    localparam int FIELD_W  = 12;
    localparam int OPC_W    = 3;
    localparam int PRM_ID_W = 4;
    localparam int PARAM_W  = 16;
    localparam int PSUM_W   = 16;
    localparam int RUN_W    = $clog2(PE_ROW) + 1; // Holds 0..PE_ROW
    localparam int ROW_ID_W = $clog2(PE_ROW);

    // Opcodes, 5 was psum write-back
    localparam logic [OPC_W-1:0] OPC_NOP     = 3'd0;
    localparam logic [OPC_W-1:0] OPC_PARAM   = 3'd1;
    localparam logic [OPC_W-1:0] OPC_LDSRAM  = 3'd2;
    localparam logic [OPC_W-1:0] OPC_STSRAM  = 3'd3; // Treated as NOP
    localparam logic [OPC_W-1:0] OPC_EX      = 3'd4;
    localparam logic [OPC_W-1:0] OPC_WBPARAM = 3'd6;

    localparam logic [PRM_ID_W-1:0] PRM_S     = 4'd0;
    localparam logic [PRM_ID_W-1:0] PRM_OC    = 4'd1;
    localparam logic [PRM_ID_W-1:0] PRM_IC    = 4'd2;
    localparam logic [PRM_ID_W-1:0] PRM_TRG   = 4'd3;
    localparam logic [PRM_ID_W-1:0] PRM_IC_WH = 4'd4; // IC bits 15:8

    // SRAM target, carried in the data byte
    localparam logic [DATA_W-1:0] TRG_ISRAM = 8'd0;
    localparam logic [DATA_W-1:0] TRG_WSRAM = 8'd1;
    localparam logic [DATA_W-1:0] TRG_PSRAM = 8'd2;

    localparam int DRAIN_CYCLES = PE_ROW + PE_COL; // Pipeline flush per tile

    // Middle field: parameter id for PARAM/WBPARAM, lane and address for LDSRAM
    typedef union packed {
        struct packed {
            logic [FIELD_W-PRM_ID_W-1:0] pad;
            logic [PRM_ID_W-1:0]         id;
        } prm;
        struct packed {
            logic [SEL_W-1:0]  sel;
            logic [ADDR_W-1:0] addr;
        } loc;
    } instr_field_u;

    typedef struct packed {
        logic              valid;
        logic [OPC_W-1:0]  opc;
        instr_field_u      fld;
        logic [DATA_W-1:0] data;
    } instr_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } cmd_t;

    typedef struct packed {
        logic              valid;
        logic [RUN_W-1:0]  run_ic;
        logic [RUN_W-1:0]  run_oc;
        logic [ADDR_W-1:0] base_i;
        logic [ADDR_W-1:0] base_w;
        logic              last;
    } tile_t;

    // One SRAM bank, lanes packed low to high
    typedef struct packed {
        logic [PE_ROW-1:0]        we;
        logic [PE_ROW-1:0]        en;
        logic [PE_ROW*ADDR_W-1:0] addr;
        logic [PE_ROW*DATA_W-1:0] din;
    } sram_wr_t;

    typedef struct packed {
        logic [PARAM_W-1:0] s;
        logic [PARAM_W-1:0] oc;
        logic [PARAM_W-1:0] ic;
    } layer_prm_t;

endpackage

//--- hw/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
    input  logic                CLK,
    input  logic                RST,
    input  sa_ctrl_pkg::instr_t instr_in,
    input  logic                busy,
    output logic                instr_stall,
    output sa_ctrl_pkg::cmd_t   cmd
);

    logic                cmd_vld;  // One-cycle command pulse
    sa_ctrl_pkg::instr_t cmd_word; // Captured instruction

    // Pending command or a running EX holds off the next word
    assign instr_stall = cmd_vld || busy;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= !instr_stall && instr_in.valid; // Invalid words die here
        end
    end

    always_ff @(posedge CLK) begin
        if (!instr_stall) begin
            cmd_word <= instr_in;
        end
    end

    assign cmd = '{valid: cmd_vld, instr: cmd_word};

endmodule

//--- hw/cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                                CLK,
    input  logic                                RST,
    input  sa_ctrl_pkg::cmd_t                   cmd,
    input  logic                                seq_done,
    output logic                                busy,
    output logic                                ex_start,
    output sa_ctrl_pkg::layer_prm_t             layer_prm,
    output sa_ctrl_pkg::sram_wr_t               sram_input,
    output sa_ctrl_pkg::sram_wr_t               sram_weight,
    output logic                                wb_valid,
    output logic [sa_ctrl_pkg::PSUM_W-1:0]      wb_data
);

    sa_ctrl_pkg::instr_field_u             fld;
    logic [sa_ctrl_pkg::DATA_W-1:0]        data;
    logic [sa_ctrl_pkg::DATA_W-1:0]        trg;     // Current LDSRAM target
    logic                                  is_prm, is_ld, is_ex, is_wb;
    logic [sa_ctrl_pkg::PSUM_W-1:0]        rd_val;  // Readback mux
    logic                                  rd_hit;  // Known parameter id
    sa_ctrl_pkg::sram_wr_t                 wr_lane; // Strobe for the addressed lane

    assign fld  = cmd.instr.fld;
    assign data = cmd.instr.data;

    // STSRAM and NOP fall through with no action
    assign is_prm = cmd.valid && (cmd.instr.opc == sa_ctrl_pkg::OPC_PARAM);
    assign is_ld  = cmd.valid && (cmd.instr.opc == sa_ctrl_pkg::OPC_LDSRAM);
    assign is_ex  = cmd.valid && (cmd.instr.opc == sa_ctrl_pkg::OPC_EX);
    assign is_wb  = cmd.valid && (cmd.instr.opc == sa_ctrl_pkg::OPC_WBPARAM);

    always_comb begin
        rd_hit = 1'b1;
        case (fld.prm.id)
            sa_ctrl_pkg::PRM_S:   rd_val = layer_prm.s;
            sa_ctrl_pkg::PRM_OC:  rd_val = layer_prm.oc;
            sa_ctrl_pkg::PRM_IC:  rd_val = layer_prm.ic;
            sa_ctrl_pkg::PRM_TRG: rd_val = sa_ctrl_pkg::PSUM_W'(trg);
            default: begin
                rd_hit = 1'b0; // No readback for IC_WH or unknown ids
                rd_val = '0;
            end
        endcase
    end

    // Only lane sel carries address and data, the rest stay zero
    always_comb begin
        wr_lane = '0;
        wr_lane.we[fld.loc.sel] = 1'b1;
        wr_lane.en[fld.loc.sel] = 1'b1;
        wr_lane.addr[fld.loc.sel*sa_ctrl_pkg::ADDR_W +: sa_ctrl_pkg::ADDR_W] = fld.loc.addr;
        wr_lane.din[fld.loc.sel*sa_ctrl_pkg::DATA_W +: sa_ctrl_pkg::DATA_W]  = data;
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy        <= 1'b0;
            ex_start    <= 1'b0;
            wb_valid    <= 1'b0;
            sram_input  <= '0;
            sram_weight <= '0;
            layer_prm   <= '0;
            trg         <= sa_ctrl_pkg::TRG_ISRAM;
        end else begin
            // Write ports idle at zero so the top can OR in feeder reads
            sram_input  <= (is_ld && trg == sa_ctrl_pkg::TRG_ISRAM) ? wr_lane : '0;
            sram_weight <= (is_ld && trg == sa_ctrl_pkg::TRG_WSRAM) ? wr_lane : '0;
            wb_valid    <= is_wb && rd_hit;
            ex_start    <= is_ex;
            if (is_ex) begin
                busy <= 1'b1;
            end else if (seq_done) begin
                busy <= 1'b0; // Layer finished
            end
            if (is_prm) begin
                case (fld.prm.id)
                    sa_ctrl_pkg::PRM_S:   layer_prm.s  <= sa_ctrl_pkg::PARAM_W'(data);
                    sa_ctrl_pkg::PRM_OC:  layer_prm.oc <= sa_ctrl_pkg::PARAM_W'(data);
                    sa_ctrl_pkg::PRM_IC:  layer_prm.ic <= sa_ctrl_pkg::PARAM_W'(data);
                    sa_ctrl_pkg::PRM_TRG: trg <= data;
                    sa_ctrl_pkg::PRM_IC_WH: begin
                        layer_prm.ic[sa_ctrl_pkg::PARAM_W-1:sa_ctrl_pkg::DATA_W] <= data;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (is_wb) begin
            wb_data <= rd_val;
        end
    end

    // No command arrives while a layer is running
    a_cmd_idle: assert property (@(posedge CLK) disable iff (RST)
        cmd.valid |-> !busy);

endmodule

//--- hw/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    ex_start,
    input  sa_ctrl_pkg::layer_prm_t layer_prm,
    input  logic                    tile_done,
    output sa_ctrl_pkg::tile_t      tile,
    output logic                    seq_done
);

    logic [sa_ctrl_pkg::PARAM_W-1:0] nxt_ic, nxt_oc;   // Start of the next tile
    logic [sa_ctrl_pkg::PARAM_W-1:0] ic_idx, oc_idx;   // Start of the tile being built
    logic [sa_ctrl_pkg::PARAM_W-1:0] ic_rem, oc_rem;
    logic [sa_ctrl_pkg::PARAM_W-1:0] bi_full, bw_full;
    logic                            ic_more, oc_more; // Another tile past this one
    logic                            issue;
    logic                            tile_vld;
    logic                            outstanding;      // Tile sent, no tile_done yet
    sa_ctrl_pkg::tile_t              tile_d, tile_q;

    assign issue  = ex_start || (tile_done && !tile_q.last);
    assign ic_idx = ex_start ? '0 : nxt_ic; // New layer starts at tile 0
    assign oc_idx = ex_start ? '0 : nxt_oc;

    assign ic_rem  = layer_prm.ic - ic_idx;
    assign oc_rem  = layer_prm.oc - oc_idx;
    assign ic_more = ic_rem > sa_ctrl_pkg::PARAM_W'(sa_ctrl_pkg::PE_ROW);
    assign oc_more = oc_rem > sa_ctrl_pkg::PARAM_W'(sa_ctrl_pkg::PE_COL);

    // Input rows stacked per IC tile, weights per OC tile
    assign bi_full = layer_prm.s * (ic_idx >> $clog2(sa_ctrl_pkg::PE_ROW));
    assign bw_full = ic_idx + layer_prm.ic * (oc_idx >> $clog2(sa_ctrl_pkg::PE_COL));

    always_comb begin
        tile_d.valid  = 1'b1;
        tile_d.run_ic = ic_more ? sa_ctrl_pkg::RUN_W'(sa_ctrl_pkg::PE_ROW)
                                : ic_rem[sa_ctrl_pkg::RUN_W-1:0];
        tile_d.run_oc = oc_more ? sa_ctrl_pkg::RUN_W'(sa_ctrl_pkg::PE_COL)
                                : oc_rem[sa_ctrl_pkg::RUN_W-1:0];
        tile_d.base_i = bi_full[sa_ctrl_pkg::ADDR_W-1:0];
        tile_d.base_w = bw_full[sa_ctrl_pkg::ADDR_W-1:0];
        // Empty layer goes out as one zero-size last tile
        tile_d.last   = (!ic_more && !oc_more) || (ic_rem == '0) || (oc_rem == '0);
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            tile_vld    <= 1'b0;
            outstanding <= 1'b0;
            nxt_ic      <= '0;
            nxt_oc      <= '0;
        end else begin
            tile_vld <= issue;
            if (tile_vld) begin
                outstanding <= 1'b1;
            end else if (tile_done) begin
                outstanding <= 1'b0;
            end
            if (issue) begin
                if (ic_more) begin
                    nxt_ic <= ic_idx + sa_ctrl_pkg::PARAM_W'(sa_ctrl_pkg::PE_ROW); // IC fastest
                    nxt_oc <= oc_idx;
                end else begin
                    nxt_ic <= '0;
                    nxt_oc <= oc_idx + sa_ctrl_pkg::PARAM_W'(sa_ctrl_pkg::PE_COL);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            tile_q <= tile_d;
        end
    end

    always_comb begin
        tile       = tile_q;
        tile.valid = tile_vld;
    end

    assign seq_done = tile_done && tile_q.last;

    // Feeder handles one tile at a time
    a_one_tile: assert property (@(posedge CLK) disable iff (RST)
        tile_vld |-> !outstanding);

endmodule

//--- hw/array_feeder.sv
`timescale 1ns/1ps

module array_feeder (
    input  logic                                              CLK,
    input  logic                                              RST,
    input  sa_ctrl_pkg::tile_t                                tile,
    input  logic [sa_ctrl_pkg::PARAM_W-1:0]                   s_len,
    output logic [sa_ctrl_pkg::PE_COL-1:0]                    weight_rd_en,
    output logic [sa_ctrl_pkg::PE_COL*sa_ctrl_pkg::ADDR_W-1:0] weight_rd_addr,
    output logic [sa_ctrl_pkg::PE_ROW-1:0]                    input_rd_en,
    output logic [sa_ctrl_pkg::PE_ROW*sa_ctrl_pkg::ADDR_W-1:0] input_rd_addr,
    output logic [sa_ctrl_pkg::ROW_ID_W-1:0]                  systolic_en_row_id,
    output logic [sa_ctrl_pkg::PE_COL-1:0]                    systolic_en_w,
    output logic                                              tile_done,
    output logic                                              flag_finish
);

    enum logic [2:0] {F_IDLE, F_PRE, F_LOAD, F_RUN, F_DRAIN, F_DONE} phase;

    sa_ctrl_pkg::tile_t                   cur;      // Tile being fed
    logic [sa_ctrl_pkg::ROW_ID_W-1:0]     load_cnt; // Weight row k
    logic [sa_ctrl_pkg::PARAM_W-1:0]      run_cnt;  // Run index, then drain count
    logic [sa_ctrl_pkg::PE_COL-1:0]       oc_mask;
    logic [sa_ctrl_pkg::PE_ROW-1:0]       ic_mask;
    logic [sa_ctrl_pkg::ADDR_W-1:0]       w_addr, i_addr;

    always_ff @(posedge CLK) begin
        if (phase == F_IDLE && tile.valid) begin
            cur <= tile;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            phase    <= F_IDLE;
            load_cnt <= '0;
            run_cnt  <= '0;
        end else begin
            case (phase)
                F_IDLE: begin
                    load_cnt <= '0;
                    if (tile.valid) begin
                        // Zero-size tile skips the array entirely
                        phase <= (tile.run_ic == '0 || tile.run_oc == '0) ? F_DONE : F_PRE;
                    end
                end
                F_PRE: phase <= F_LOAD;
                F_LOAD: begin
                    run_cnt <= '0;
                    if (&load_cnt) begin
                        phase <= (s_len == '0) ? F_DRAIN : F_RUN;
                    end else begin
                        load_cnt <= load_cnt + 1'b1;
                        phase    <= F_PRE;
                    end
                end
                F_RUN: begin
                    if (run_cnt == s_len - 1'b1) begin
                        run_cnt <= '0;
                        phase   <= F_DRAIN;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                F_DRAIN: begin
                    if (run_cnt == sa_ctrl_pkg::PARAM_W'(sa_ctrl_pkg::DRAIN_CYCLES - 1)) begin
                        phase <= F_DONE;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                default: phase <= F_IDLE; // F_DONE
            endcase
        end
    end

    // Thermometer masks, run of 4 gives all lanes
    assign oc_mask = ~({sa_ctrl_pkg::PE_COL{1'b1}} << cur.run_oc);
    assign ic_mask = ~({sa_ctrl_pkg::PE_ROW{1'b1}} << cur.run_ic);
    assign w_addr  = cur.base_w + sa_ctrl_pkg::ADDR_W'(load_cnt);
    assign i_addr  = cur.base_i + run_cnt[sa_ctrl_pkg::ADDR_W-1:0];

    assign weight_rd_en = (phase == F_PRE) ? oc_mask : '0;
    assign input_rd_en  = (phase == F_RUN) ? ic_mask : '0;

    always_comb begin
        for (int i = 0; i < sa_ctrl_pkg::PE_COL; i++) begin
            weight_rd_addr[i*sa_ctrl_pkg::ADDR_W +: sa_ctrl_pkg::ADDR_W] =
                weight_rd_en[i] ? w_addr : '0;
        end
        for (int i = 0; i < sa_ctrl_pkg::PE_ROW; i++) begin
            input_rd_addr[i*sa_ctrl_pkg::ADDR_W +: sa_ctrl_pkg::ADDR_W] =
                input_rd_en[i] ? i_addr : '0;
        end
    end

    // Row k latches the weights read in the preceding cycle
    assign systolic_en_row_id = (phase == F_LOAD) ? load_cnt : '0;
    assign systolic_en_w      = {sa_ctrl_pkg::PE_COL{phase == F_LOAD}};

    assign tile_done   = (phase == F_DONE);
    assign flag_finish = tile_done && cur.last;

    // A new tile only arrives once the previous one is done
    a_tile_idle: assert property (@(posedge CLK) disable iff (RST)
        tile.valid |-> phase == F_IDLE);

endmodule

//--- hw/systolic_ctrl.sv
`timescale 1ns/1ps

module systolic_ctrl (
    input  logic                                  CLK,
    input  logic                                  RST,
    input  sa_ctrl_pkg::instr_t                   instr_in,
    output logic                                  instr_stall,
    output sa_ctrl_pkg::sram_wr_t                 sram_input,
    output sa_ctrl_pkg::sram_wr_t                 sram_weight,
    output logic [sa_ctrl_pkg::ROW_ID_W-1:0]      systolic_en_row_id,
    output logic [sa_ctrl_pkg::PE_COL-1:0]        systolic_en_w,
    output logic                                  wb_valid,
    output logic [sa_ctrl_pkg::PSUM_W-1:0]        wb_data,
    output logic                                  flag_finish
);

    logic                                              busy;
    sa_ctrl_pkg::cmd_t                                 cmd;
    logic                                              ex_start;
    sa_ctrl_pkg::layer_prm_t                           layer_prm;
    sa_ctrl_pkg::sram_wr_t                             wr_input, wr_weight; // LDSRAM side
    logic                                              seq_done;
    sa_ctrl_pkg::tile_t                                tile;
    logic                                              tile_done;
    logic [sa_ctrl_pkg::PE_COL-1:0]                    w_rd_en;
    logic [sa_ctrl_pkg::PE_COL*sa_ctrl_pkg::ADDR_W-1:0] w_rd_addr;
    logic [sa_ctrl_pkg::PE_ROW-1:0]                    i_rd_en;
    logic [sa_ctrl_pkg::PE_ROW*sa_ctrl_pkg::ADDR_W-1:0] i_rd_addr;

    instr_fetch u_fetch (
        .CLK(CLK), .RST(RST),
        .instr_in(instr_in), .busy(busy),
        .instr_stall(instr_stall), .cmd(cmd)
    );

    cmd_dispatch u_dispatch (
        .CLK(CLK), .RST(RST),
        .cmd(cmd), .seq_done(seq_done),
        .busy(busy), .ex_start(ex_start), .layer_prm(layer_prm),
        .sram_input(wr_input), .sram_weight(wr_weight),
        .wb_valid(wb_valid), .wb_data(wb_data)
    );

    tile_sequencer u_seq (
        .CLK(CLK), .RST(RST),
        .ex_start(ex_start), .layer_prm(layer_prm), .tile_done(tile_done),
        .tile(tile), .seq_done(seq_done)
    );

    array_feeder u_feed (
        .CLK(CLK), .RST(RST),
        .tile(tile), .s_len(layer_prm.s),
        .weight_rd_en(w_rd_en), .weight_rd_addr(w_rd_addr),
        .input_rd_en(i_rd_en), .input_rd_addr(i_rd_addr),
        .systolic_en_row_id(systolic_en_row_id), .systolic_en_w(systolic_en_w),
        .tile_done(tile_done), .flag_finish(flag_finish)
    );

    // Writes only between instructions, reads only during EX
    assign sram_input = '{we:   wr_input.we,
                          en:   wr_input.en | i_rd_en,
                          addr: wr_input.addr | i_rd_addr,
                          din:  wr_input.din};
    assign sram_weight = '{we:   wr_weight.we,
                           en:   wr_weight.en | w_rd_en,
                           addr: wr_weight.addr | w_rd_addr,
                           din:  wr_weight.din};

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK; // 4 ns period
    end

    initial begin
        RST = 1'b1;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0; // Released away from the rising edge
    end

endmodule

//--- tb/tb_systolic_ctrl.sv
`timescale 1ns/1ps

module tb_systolic_ctrl;

    localparam int MAX_TESTS = 32;
    localparam logic [3:0] EV_NONE = 4'd0;
    localparam logic [3:0] EV_PRE  = 4'd1; // Weight read for one row
    localparam logic [3:0] EV_LOAD = 4'd2; // Row latch
    localparam logic [3:0] EV_RUN  = 4'd3; // Input read
    localparam logic [3:0] EV_FIN  = 4'd4;

    // One cycle of array-side activity
    typedef struct packed {
        logic [3:0]                     kind;
        logic [3:0]                     mask;
        logic [sa_ctrl_pkg::ADDR_W-1:0] val;  // Address or row id
    } ev_t;

    logic                             CLK, RST;
    sa_ctrl_pkg::instr_t              instr_in;
    logic                             instr_stall;
    sa_ctrl_pkg::sram_wr_t            sram_input, sram_weight;
    logic [sa_ctrl_pkg::ROW_ID_W-1:0] systolic_en_row_id;
    logic [sa_ctrl_pkg::PE_COL-1:0]   systolic_en_w;
    logic                             wb_valid;
    logic [sa_ctrl_pkg::PSUM_W-1:0]   wb_data;
    logic                             flag_finish;

    logic [31:0] pat [3*MAX_TESTS]; // id, word, expected
    ev_t         exp_q [$];
    int          tests, failed, errors, test_errors;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          ref_s, ref_oc, ref_ic; // Layer registers as the DUT should hold them
    logic [7:0]  ref_trg;

    tb_clock u_clock (.CLK(CLK), .RST(RST));

    systolic_ctrl DUT (
        .CLK(CLK), .RST(RST), .instr_in(instr_in), .instr_stall(instr_stall),
        .sram_input(sram_input), .sram_weight(sram_weight),
        .systolic_en_row_id(systolic_en_row_id), .systolic_en_w(systolic_en_w),
        .wb_valid(wb_valid), .wb_data(wb_data), .flag_finish(flag_finish)
    );

    task automatic verify(input bit ok, input string what);
        assert (ok) else begin
            $display("Error at %0d ns: %s", $time, what);
            test_errors++;
        end
    endtask

    function automatic logic [sa_ctrl_pkg::ADDR_W-1:0] lane_addr(
        input sa_ctrl_pkg::sram_wr_t b, input int lane);
        return b.addr[lane*sa_ctrl_pkg::ADDR_W +: sa_ctrl_pkg::ADDR_W];
    endfunction

    // All enabled lanes read the same row
    function automatic bit lanes_agree(input sa_ctrl_pkg::sram_wr_t b);
        bit ok;
        ok = 1'b1;
        for (int i = 1; i < sa_ctrl_pkg::PE_ROW; i++) begin
            if (b.en[i] && lane_addr(b, i) != lane_addr(b, 0)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic [3:0] lanes_below(input int run);
        return 4'((1 << run) - 1);
    endfunction

    function automatic ev_t make_ev(input logic [3:0] kind, input logic [3:0] mask, input int v);
        return '{kind: kind, mask: mask, val: sa_ctrl_pkg::ADDR_W'(v)};
    endfunction

    function automatic bit quiet();
        return sram_input.en == '0 && sram_weight.en == '0 && sram_input.we == '0
            && sram_weight.we == '0 && systolic_en_w == '0 && !wb_valid && !flag_finish;
    endfunction

    // Expected activity of one EX, tiles IC fastest
    function automatic int build_tile_events();
        int tiles, run_ic, run_oc, base_i, base_w;
        tiles = 0;
        exp_q.delete();
        for (int oc0 = 0; oc0 < ref_oc; oc0 += sa_ctrl_pkg::PE_COL) begin
            for (int ic0 = 0; ic0 < ref_ic; ic0 += sa_ctrl_pkg::PE_ROW) begin
                run_ic = (ref_ic - ic0 < sa_ctrl_pkg::PE_ROW) ? ref_ic - ic0 : sa_ctrl_pkg::PE_ROW;
                run_oc = (ref_oc - oc0 < sa_ctrl_pkg::PE_COL) ? ref_oc - oc0 : sa_ctrl_pkg::PE_COL;
                base_i = ref_s * (ic0 / sa_ctrl_pkg::PE_ROW);
                base_w = ic0 + ref_ic * (oc0 / sa_ctrl_pkg::PE_COL);
                for (int k = 0; k < sa_ctrl_pkg::PE_ROW; k++) begin
                    exp_q.push_back(make_ev(EV_PRE, lanes_below(run_oc), base_w + k));
                    exp_q.push_back(make_ev(EV_LOAD, 4'hf, k)); // Row k latches
                end
                for (int r = 0; r < ref_s; r++) begin
                    exp_q.push_back(make_ev(EV_RUN, lanes_below(run_ic), base_i + r));
                end
                tiles++;
            end
        end
        exp_q.push_back(make_ev(EV_FIN, 4'h0, 0)); // Empty layer still flags once
        return tiles;
    endfunction

    task automatic observe_cycle(output ev_t e);
        int active;
        active = int'(sram_weight.en != '0) + int'(systolic_en_w != '0)
               + int'(sram_input.en != '0) + int'(flag_finish);
        verify(active <= 1, "more than one array activity in one cycle");
        verify(sram_input.we == '0 && sram_weight.we == '0 && !wb_valid,
               "write strobe or readback during EX");
        e = make_ev(EV_NONE, 4'h0, 0);
        if (sram_weight.en != '0) begin
            verify(lanes_agree(sram_weight), "weight lanes read different rows");
            e = make_ev(EV_PRE, sram_weight.en, int'(lane_addr(sram_weight, 0)));
        end else if (systolic_en_w != '0) begin
            e = make_ev(EV_LOAD, systolic_en_w, int'(systolic_en_row_id));
        end else if (sram_input.en != '0) begin
            verify(lanes_agree(sram_input), "input lanes read different rows");
            e = make_ev(EV_RUN, sram_input.en, int'(lane_addr(sram_input, 0)));
        end else if (flag_finish) begin
            e = make_ev(EV_FIN, 4'h0, 0);
        end
    endtask

    // Hold the word from a falling edge until a rising edge sees stall low
    task automatic issue_word(input sa_ctrl_pkg::instr_t w);
        @(negedge CLK);
        instr_in = w;
        while (instr_stall) begin
            @(negedge CLK);
        end
        @(negedge CLK); // Taken, now in the command cycle
        instr_in = '0;
    endtask

    task automatic follow_ex(input logic [31:0] expv);
        ev_t got;
        ev_t want;
        bit  done;
        int  tiles;
        tiles = build_tile_events();
        verify(tiles == int'(expv), $sformatf("tile count %0d, pattern says %0d", tiles, expv));
        done = 1'b0;
        while (!done) begin
            verify(instr_stall, "stall dropped while EX was running");
            observe_cycle(got);
            if (got.kind != EV_NONE) begin
                want = make_ev(EV_NONE, 4'h0, 0);
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                end
                verify(got == want, $sformatf("array event %h, expected %h", got, want));
                done = (got.kind == EV_FIN);
            end
            @(negedge CLK);
        end
        verify(exp_q.size() == 0, $sformatf("%0d array events never came", exp_q.size()));
        verify(!instr_stall && !flag_finish, "stall or finish flag held after EX"); // Busy gone
    endtask

    task automatic watch_strobes(input sa_ctrl_pkg::instr_t w, input logic [31:0] expv);
        bit                    ld, wb;
        int                    sel;
        logic [3:0]            in_we, wt_we;
        sa_ctrl_pkg::sram_wr_t bank;
        ld    = w.valid && w.opc == sa_ctrl_pkg::OPC_LDSRAM;
        wb    = w.valid && w.opc == sa_ctrl_pkg::OPC_WBPARAM;
        sel   = int'(w.fld.loc.sel);
        in_we = (ld && ref_trg == sa_ctrl_pkg::TRG_ISRAM) ? 4'(1 << sel) : 4'h0;
        wt_we = (ld && ref_trg == sa_ctrl_pkg::TRG_WSRAM) ? 4'(1 << sel) : 4'h0;
        verify(instr_stall == w.valid, "stall does not follow the taken word");
        verify(quiet(), "output activity in the command cycle");
        @(negedge CLK);
        verify(!instr_stall, "stall held past the minimum spacing");
        verify(sram_input.we == in_we && sram_input.en == in_we,
               $sformatf("input we/en %h/%h, expected %h", sram_input.we, sram_input.en, in_we));
        verify(sram_weight.we == wt_we && sram_weight.en == wt_we,
               $sformatf("weight we/en %h/%h, expected %h", sram_weight.we, sram_weight.en, wt_we));
        bank = (in_we != '0) ? sram_input : sram_weight;
        if ((in_we | wt_we) != '0) begin
            verify(lane_addr(bank, sel) == w.fld.loc.addr
                   && bank.din[sel*sa_ctrl_pkg::DATA_W +: sa_ctrl_pkg::DATA_W] == w.data,
                   $sformatf("lane %0d addr/data %h/%h, expected %h/%h", sel, lane_addr(bank, sel),
                             bank.din[sel*sa_ctrl_pkg::DATA_W +: sa_ctrl_pkg::DATA_W],
                             w.fld.loc.addr, w.data));
        end
        verify(wb_valid == wb, $sformatf("wb_valid %b, expected %b", wb_valid, wb));
        if (wb) begin
            verify(wb_data == expv[15:0], $sformatf("readback %h, expected %h", wb_data, expv[15:0]));
        end
        verify(systolic_en_w == '0 && !flag_finish, "array activity outside EX");
        @(negedge CLK);
        verify(quiet(), "strobe held longer than one cycle");
    endtask

    // Reference copy of the layer registers
    function automatic void apply_param(input sa_ctrl_pkg::instr_t w);
        if (w.valid && w.opc == sa_ctrl_pkg::OPC_PARAM) begin
            case (w.fld.prm.id)
                sa_ctrl_pkg::PRM_S:     ref_s   = int'(w.data);
                sa_ctrl_pkg::PRM_OC:    ref_oc  = int'(w.data);
                sa_ctrl_pkg::PRM_IC:    ref_ic  = int'(w.data);
                sa_ctrl_pkg::PRM_TRG:   ref_trg = w.data;
                sa_ctrl_pkg::PRM_IC_WH: ref_ic  = (ref_ic & 'hff) | (int'(w.data) << 8);
                default: ;
            endcase
        end
    endfunction

    // 20 cycles per word, EX adds its tiles at S plus preload and drain
    function automatic int cycle_budget();
        int                  total, s;
        sa_ctrl_pkg::instr_t w;
        total = 10;
        s = 0;
        for (int n = 0; n < MAX_TESTS && pat[3*n] != 32'hff; n++) begin
            w = pat[3*n+1][23:0];
            if (w.valid && w.opc == sa_ctrl_pkg::OPC_PARAM && w.fld.prm.id == sa_ctrl_pkg::PRM_S) begin
                s = int'(w.data);
            end
            total += 20;
            if (w.valid && w.opc == sa_ctrl_pkg::OPC_EX) begin
                total += int'(pat[3*n+2]) * (2*sa_ctrl_pkg::PE_ROW + s + sa_ctrl_pkg::DRAIN_CYCLES + 4);
            end
        end
        return total;
    endfunction

    function automatic string op_name(input sa_ctrl_pkg::instr_t w);
        if (!w.valid) begin
            return "dropped";
        end
        case (w.opc)
            sa_ctrl_pkg::OPC_PARAM:   return "PARAM";
            sa_ctrl_pkg::OPC_LDSRAM:  return "LDSRAM";
            sa_ctrl_pkg::OPC_STSRAM:  return "STSRAM";
            sa_ctrl_pkg::OPC_EX:      return "EX";
            sa_ctrl_pkg::OPC_WBPARAM: return "WBPARAM";
            default:                  return "NOP";
        endcase
    endfunction

    task automatic finish_test(input logic [7:0] id, input string name);
        tests++;
        errors += test_errors;
        if (test_errors != 0) begin
            failed++;
        end
        $display("Test %02h %-7s %s", id, name, (test_errors == 0) ? "ok" : "FAIL");
    endtask

    task automatic run_test(input logic [31:0] id, input sa_ctrl_pkg::instr_t w,
                            input logic [31:0] expv);
        test_errors = 0;
        issue_word(w);
        if (w.valid && w.opc == sa_ctrl_pkg::OPC_EX) begin
            follow_ex(expv);
        end else begin
            watch_strobes(w, expv);
        end
        apply_param(w); // Register took it at the end of the command cycle
        finish_test(id[7:0], op_name(w));
    endtask

    // Watchdog
    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        instr_in    = '0;
        tests       = 0;
        failed      = 0;
        errors      = 0;
        test_errors = 0;
        ref_s       = 0;
        ref_oc      = 0;
        ref_ic      = 0;
        ref_trg     = sa_ctrl_pkg::TRG_ISRAM;
        $readmemh("tb/instr_patterns.txt", pat);
        cycle_limit = cycle_budget();
        @(negedge RST);
        verify(!instr_stall && quiet(), "outputs not idle after reset");
        finish_test(8'h00, "reset");
        for (int n = 0; n < MAX_TESTS && pat[3*n] != 32'hff; n++) begin
            run_test(pat[3*n], pat[3*n+1][23:0], pat[3*n+2]);
        end
        $display("Done: %0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/instr_patterns.txt
// id  word    expected (readback value for WBPARAM, tile count for EX, else 0)
// word = {valid, opcode[2:0], field[11:0], data[7:0]}, ff ends the list
01 900003 0000 // S = 3
02 e00000 0003
03 900105 0000 // OC = 5
04 e00100 0005
05 900206 0000 // IC = 6
06 900412 0000 // IC high byte 12
07 e00200 1206
08 900400 0000 // IC high byte back to 0
09 e00200 0006
0a 900300 0000 // Target input SRAM
0b e00300 0000
0c a8155a 0000 // Lane 2, addr 015
0d 900301 0000 // Target weight SRAM
0e e00300 0001
0f a7ffc3 0000 // Lane 1, addr 3ff
10 900302 0000 // Target psum SRAM
11 e00300 0002
12 ac0177 0000 // No strobe
13 400000 0000 // EX with valid clear
14 800000 0000
15 b00000 0000 // STSRAM acts as NOP
16 c00000 0004 // IC 6, OC 5, S 3
17 900100 0000 // OC = 0
18 c00000 0000 // Empty layer
ff 000000 0000

//--- all.f
hw/sa_ctrl_pkg.sv
hw/instr_fetch.sv
hw/cmd_dispatch.sv
hw/tile_sequencer.sv
hw/array_feeder.sv
hw/systolic_ctrl.sv
tb/tb_clock.sv
tb/tb_systolic_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the systolic controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_systolic_ctrl -Mdir "$OBJ" -f all.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$OBJ/Vtb_systolic_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line in $LOG"
    exit 1
fi
exit 0
